// ==== byte_counter.sv ====
`timescale 1ns/1ps

module byte_counter (
	input logic clk,
	input logic reset,
	input logic clear,
	input logic en,
	input logic [15:0] limit,
	output logic [15:0] count,
	output logic last
);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			count <= 16'd0;
		end else if (clear) begin
			count <= 16'd0;
		end else if (en) begin
			count <= count + 16'd1;
		end
	end

	// the byte being counted now is the final one
	assign last = (count + 16'd1) == limit;

	a_count_in_range: assert property (@(posedge clk) disable iff (reset)
		en |-> count < limit);

endmodule

// ==== byte_fifo.sv ====
`timescale 1ns/1ps

module byte_fifo (
	input logic clk,
	input logic reset,
	input logic wr,
	input logic [7:0] wdata,
	input logic rd,
	output logic [7:0] rd_data,
	output logic rd_valid,
	output logic empty,
	output logic full
);

	logic [7:0] mem [0:(1 << ipv4_pkg::fifo_aw) - 1];
	// extra top bit tells full from empty
	logic [ipv4_pkg::fifo_aw:0] wr_ptr;
	logic [ipv4_pkg::fifo_aw:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign empty = wr_ptr == rd_ptr;
	assign full = (wr_ptr[ipv4_pkg::fifo_aw] != rd_ptr[ipv4_pkg::fifo_aw]) &&
		(wr_ptr[ipv4_pkg::fifo_aw - 1:0] == rd_ptr[ipv4_pkg::fifo_aw - 1:0]);
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= do_rd;
			if (do_wr) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr) begin
			mem[wr_ptr[ipv4_pkg::fifo_aw - 1:0]] <= wdata;
		end
		if (do_rd) begin
			rd_data <= mem[rd_ptr[ipv4_pkg::fifo_aw - 1:0]];
		end
	end

	a_no_read_empty: assert property (@(posedge clk) disable iff (reset)
		rd |-> !empty);

endmodule

// ==== ipv4_over_eth.sv ====
`timescale 1ns/1ps

module ipv4_over_eth (
	input logic clk,
	input logic reset,
	input logic rx_frame_start,
	input logic [15:0] rx_ethertype,
	input logic rx_valid,
	input logic [7:0] rx_data,
	output logic head_valid,
	output logic head_error,
	output logic [5:0] head_dscp,
	output logic [15:0] head_total_length,
	output logic [15:0] head_id,
	output logic [7:0] head_ttl,
	output logic [7:0] head_protocol,
	output logic [31:0] head_src,
	output logic [31:0] head_dst,
	output logic pay_valid,
	output logic [7:0] pay_data,
	output logic rx_done,
	output logic rx_busy,
	input logic tx_start,
	input logic [5:0] tx_dscp,
	input logic [15:0] tx_total_length,
	input logic [15:0] tx_id,
	input logic [7:0] tx_ttl,
	input logic [7:0] tx_protocol,
	input logic [31:0] tx_src,
	input logic [31:0] tx_dst,
	input logic tx_wr,
	input logic [7:0] tx_wdata,
	output logic eth_tx_valid,
	output logic [7:0] eth_tx_data,
	output logic tx_busy,
	output logic tx_full
);

	logic byte_en;
	logic head_phase;
	logic pay_phase;
	logic head_done;
	logic [5:0] hdr_bytes;
	logic [15:0] rx_pay_len;

	logic load;
	logic sum_en;
	logic shift_en;
	logic pay_rd;
	logic [15:0] tx_pay_len;
	logic [7:0] fifo_rd_data;
	logic fifo_rd_valid;
	logic fifo_empty;

	// receive path
	ipv4_rx_ctrl u_rx_ctrl (
		.clk(clk),
		.reset(reset),
		.rx_frame_start(rx_frame_start),
		.rx_ethertype(rx_ethertype),
		.rx_valid(rx_valid),
		.hdr_bytes(hdr_bytes),
		.pay_len(rx_pay_len),
		.byte_en(byte_en),
		.head_phase(head_phase),
		.pay_phase(pay_phase),
		.head_done(head_done),
		.rx_done(rx_done),
		.rx_busy(rx_busy)
	);

	ipv4_rx_head u_rx_head (
		.clk(clk),
		.reset(reset),
		.rx_data(rx_data),
		.byte_en(byte_en),
		.head_phase(head_phase),
		.pay_phase(pay_phase),
		.head_done(head_done),
		.hdr_bytes(hdr_bytes),
		.pay_len(rx_pay_len),
		.head_valid(head_valid),
		.head_error(head_error),
		.head_dscp(head_dscp),
		.head_total_length(head_total_length),
		.head_id(head_id),
		.head_ttl(head_ttl),
		.head_protocol(head_protocol),
		.head_src(head_src),
		.head_dst(head_dst),
		.pay_valid(pay_valid),
		.pay_data(pay_data)
	);

	// transmit path
	ipv4_tx_ctrl u_tx_ctrl (
		.clk(clk),
		.reset(reset),
		.tx_start(tx_start),
		.pay_len(tx_pay_len),
		.fifo_empty(fifo_empty),
		.load(load),
		.sum_en(sum_en),
		.shift_en(shift_en),
		.pay_rd(pay_rd),
		.tx_busy(tx_busy)
	);

	ipv4_tx_head u_tx_head (
		.clk(clk),
		.reset(reset),
		.load(load),
		.sum_en(sum_en),
		.shift_en(shift_en),
		.tx_dscp(tx_dscp),
		.tx_total_length(tx_total_length),
		.tx_id(tx_id),
		.tx_ttl(tx_ttl),
		.tx_protocol(tx_protocol),
		.tx_src(tx_src),
		.tx_dst(tx_dst),
		.rd_valid(fifo_rd_valid),
		.rd_data(fifo_rd_data),
		.pay_len(tx_pay_len),
		.eth_tx_valid(eth_tx_valid),
		.eth_tx_data(eth_tx_data)
	);

	byte_fifo u_fifo (
		.clk(clk),
		.reset(reset),
		.wr(tx_wr),
		.wdata(tx_wdata),
		.rd(pay_rd),
		.rd_data(fifo_rd_data),
		.rd_valid(fifo_rd_valid),
		.empty(fifo_empty),
		.full(tx_full)
	);

endmodule

// ==== ipv4_pkg.sv ====
package ipv4_pkg;

	localparam logic [15:0] ethertype_ipv4 = 16'h0800;

	// header length in 32-bit words
	localparam int min_ihl = 5;
	localparam int max_ihl = 15;

	localparam int tx_head_bytes = 20;

	// 32 entries
	localparam int fifo_aw = 5;

	typedef enum logic [1:0] {
		rx_idle,
		rx_head,
		rx_payload,
		rx_skip
	} rx_state_t;

	typedef enum logic [1:0] {
		tx_idle,
		tx_sum,
		tx_head,
		tx_payload
	} tx_state_t;

	typedef struct packed {
		logic [3:0] version;
		logic [3:0] ihl;
		logic [5:0] dscp;
		logic [1:0] ecn;
		logic [15:0] total_length;
	} ipv4_word0_t;

	// first header word, shifted in or out as raw bytes
	typedef union packed {
		logic [31:0] raw;
		ipv4_word0_t f;
	} ipv4_word0_u;

endpackage

// ==== ipv4_rx_ctrl.sv ====
`timescale 1ns/1ps

module ipv4_rx_ctrl (
	input logic clk,
	input logic reset,
	input logic rx_frame_start,
	input logic [15:0] rx_ethertype,
	input logic rx_valid,
	input logic [5:0] hdr_bytes,
	input logic [15:0] pay_len,
	output logic byte_en,
	output logic head_phase,
	output logic pay_phase,
	output logic head_done,
	output logic rx_done,
	output logic rx_busy
);

	ipv4_pkg::rx_state_t state;
	logic start_ok;
	logic match;
	logic cnt_last;
	logic pay_last;
	logic [15:0] limit;

	// a new frame start is ignored while a header is still coming in
	assign start_ok = rx_frame_start && (state != ipv4_pkg::rx_head);
	assign match = rx_ethertype == ipv4_pkg::ethertype_ipv4;

	assign head_phase = state == ipv4_pkg::rx_head;
	assign pay_phase = state == ipv4_pkg::rx_payload;
	assign byte_en = rx_valid && (head_phase || pay_phase);
	assign head_done = head_phase && byte_en && cnt_last;
	assign pay_last = pay_phase && byte_en && cnt_last;
	assign rx_busy = head_phase || pay_phase;

	assign limit = pay_phase ? pay_len : {10'd0, hdr_bytes};

	byte_counter u_cnt (
		.clk(clk),
		.reset(reset),
		.clear(start_ok || head_done),
		.en(byte_en),
		.limit(limit),
		.count(),
		.last(cnt_last)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ipv4_pkg::rx_idle;
			rx_done <= 1'b0;
		end else begin
			rx_done <= pay_last || (head_done && pay_len == 16'd0);
			if (start_ok) begin
				state <= match ? ipv4_pkg::rx_head : ipv4_pkg::rx_skip;
			end else if (head_done) begin
				state <= (pay_len == 16'd0) ? ipv4_pkg::rx_idle : ipv4_pkg::rx_payload;
			end else if (pay_last) begin
				state <= ipv4_pkg::rx_idle;
			end
		end
	end

	// payload length must hold while its bytes are counted
	a_pay_len_stable: assert property (@(posedge clk) disable iff (reset)
		pay_phase && $past(pay_phase) |-> $stable(pay_len));

endmodule

// ==== ipv4_rx_head.sv ====
`timescale 1ns/1ps

module ipv4_rx_head (
	input logic clk,
	input logic reset,
	input logic [7:0] rx_data,
	input logic byte_en,
	input logic head_phase,
	input logic pay_phase,
	input logic head_done,
	output logic [5:0] hdr_bytes,
	output logic [15:0] pay_len,
	output logic head_valid,
	output logic head_error,
	output logic [5:0] head_dscp,
	output logic [15:0] head_total_length,
	output logic [15:0] head_id,
	output logic [7:0] head_ttl,
	output logic [7:0] head_protocol,
	output logic [31:0] head_src,
	output logic [31:0] head_dst,
	output logic pay_valid,
	output logic [7:0] pay_data
);

	ipv4_pkg::ipv4_word0_u w0;
	ipv4_pkg::ipv4_word0_u w0_next;
	// bytes 4 to 19 of the base header
	logic [(ipv4_pkg::min_ihl - 1) * 32 - 1:0] rest;
	logic [(ipv4_pkg::min_ihl - 1) * 32 - 1:0] rest_next;
	logic [$clog2(ipv4_pkg::max_ihl * 4 + 1) - 1:0] pos;
	logic [7:0] hi_byte;
	logic [15:0] sum;
	logic [15:0] sum_next;
	logic [16:0] sum_wide;
	logic [3:0] ihl_eff;
	logic take;

	assign take = head_phase && byte_en;

	// a short IHL still consumes a base header, and is flagged as an error
	assign ihl_eff = (w0.f.ihl < 4'(ipv4_pkg::min_ihl)) ? 4'(ipv4_pkg::min_ihl) : w0.f.ihl;
	assign hdr_bytes = {ihl_eff, 2'b00};
	assign pay_len = (w0.f.total_length > {10'd0, hdr_bytes}) ?
		w0.f.total_length - {10'd0, hdr_bytes} : 16'd0;

	assign sum_wide = {1'b0, sum} + {1'b0, hi_byte, rx_data};

	always_comb begin
		w0_next = w0;
		rest_next = rest;
		sum_next = sum;
		if (take) begin
			if (pos < 4) begin
				w0_next.raw = {w0.raw[23:0], rx_data};
			end else if (pos < ipv4_pkg::min_ihl * 4) begin
				rest_next = {rest[119:0], rx_data};
			end
			// odd byte closes a 16-bit pair, end-around carry
			if (pos[0]) begin
				sum_next = sum_wide[15:0] + {15'd0, sum_wide[16]};
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			w0 <= '0;
			pos <= '0;
			sum <= 16'd0;
			head_valid <= 1'b0;
			pay_valid <= 1'b0;
		end else begin
			w0 <= w0_next;
			if (!head_phase) begin
				pos <= '0;
			end else if (take) begin
				pos <= pos + 1'b1;
			end
			sum <= head_phase ? sum_next : 16'd0;
			head_valid <= head_done;
			pay_valid <= pay_phase && byte_en;
		end
	end

	always_ff @(posedge clk) begin
		rest <= rest_next;
		if (take && !pos[0]) begin
			hi_byte <= rx_data;
		end
		if (pay_phase && byte_en) begin
			pay_data <= rx_data;
		end
		// fields are held until the next header completes
		if (head_done) begin
			head_error <= (sum_next != 16'hffff) || (w0.f.ihl < 4'(ipv4_pkg::min_ihl));
			head_dscp <= w0.f.dscp;
			head_total_length <= w0.f.total_length;
			head_id <= rest_next[127:112];
			head_ttl <= rest_next[95:88];
			head_protocol <= rest_next[87:80];
			head_src <= rest_next[63:32];
			head_dst <= rest_next[31:0];
		end
	end

endmodule

// ==== ipv4_tx_ctrl.sv ====
`timescale 1ns/1ps

module ipv4_tx_ctrl (
	input logic clk,
	input logic reset,
	input logic tx_start,
	input logic [15:0] pay_len,
	input logic fifo_empty,
	output logic load,
	output logic sum_en,
	output logic shift_en,
	output logic pay_rd,
	output logic tx_busy
);

	ipv4_pkg::tx_state_t state;
	logic [15:0] limit;
	logic cnt_en;
	logic cnt_last;
	logic step_last;
	// covers the fifo read and output register after the last read
	logic [1:0] drain;

	assign load = tx_start && !tx_busy;
	assign sum_en = state == ipv4_pkg::tx_sum;
	assign shift_en = state == ipv4_pkg::tx_head;
	assign pay_rd = (state == ipv4_pkg::tx_payload) && !fifo_empty;
	assign tx_busy = (state != ipv4_pkg::tx_idle) || (drain != 2'b00);

	assign cnt_en = sum_en || shift_en || pay_rd;
	assign step_last = cnt_en && cnt_last;

	always_comb begin
		case (state)
			ipv4_pkg::tx_sum: limit = 16'(ipv4_pkg::tx_head_bytes / 2);
			ipv4_pkg::tx_head: limit = 16'(ipv4_pkg::tx_head_bytes);
			default: limit = pay_len;
		endcase
	end

	byte_counter u_cnt (
		.clk(clk),
		.reset(reset),
		.clear(load || step_last),
		.en(cnt_en),
		.limit(limit),
		.count(),
		.last(cnt_last)
	);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ipv4_pkg::tx_idle;
			drain <= 2'b00;
		end else begin
			drain <= {drain[0], pay_rd && cnt_last};
			case (state)
				ipv4_pkg::tx_idle: begin
					if (load) begin
						state <= ipv4_pkg::tx_sum;
					end
				end
				ipv4_pkg::tx_sum: begin
					if (step_last) begin
						state <= ipv4_pkg::tx_head;
					end
				end
				ipv4_pkg::tx_head: begin
					if (step_last) begin
						state <= (pay_len == 16'd0) ? ipv4_pkg::tx_idle : ipv4_pkg::tx_payload;
					end
				end
				default: begin
					if (step_last) begin
						state <= ipv4_pkg::tx_idle;
					end
				end
			endcase
		end
	end

endmodule

// ==== ipv4_tx_head.sv ====
`timescale 1ns/1ps

module ipv4_tx_head (
	input logic clk,
	input logic reset,
	input logic load,
	input logic sum_en,
	input logic shift_en,
	input logic [5:0] tx_dscp,
	input logic [15:0] tx_total_length,
	input logic [15:0] tx_id,
	input logic [7:0] tx_ttl,
	input logic [7:0] tx_protocol,
	input logic [31:0] tx_src,
	input logic [31:0] tx_dst,
	input logic rd_valid,
	input logic [7:0] rd_data,
	output logic [15:0] pay_len,
	output logic eth_tx_valid,
	output logic [7:0] eth_tx_data
);

	ipv4_pkg::ipv4_word0_u w0;
	logic [ipv4_pkg::tx_head_bytes * 8 - 1:0] hdr;
	logic [15:0] sum;
	logic [16:0] sum_wide;
	logic sum_d;
	logic pay_q_valid;
	logic [7:0] pay_q;

	always_comb begin
		w0.f.version = 4'd4;
		w0.f.ihl = 4'(ipv4_pkg::min_ihl);
		w0.f.dscp = tx_dscp;
		w0.f.ecn = 2'b00;
		w0.f.total_length = tx_total_length;
	end

	assign sum_wide = {1'b0, sum} + {1'b0, hdr[159:144]};

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sum <= 16'd0;
			sum_d <= 1'b0;
			pay_q_valid <= 1'b0;
			pay_len <= 16'd0;
		end else begin
			sum_d <= sum_en;
			pay_q_valid <= rd_valid;
			if (load) begin
				sum <= 16'd0;
				pay_len <= (tx_total_length > 16'(ipv4_pkg::tx_head_bytes)) ?
					tx_total_length - 16'(ipv4_pkg::tx_head_bytes) : 16'd0;
			end else if (sum_en) begin
				sum <= sum_wide[15:0] + {15'd0, sum_wide[16]};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			// flags, fragment offset and checksum start at zero
			hdr <= {w0.raw, tx_id, 16'h0000, tx_ttl, tx_protocol, 16'h0000, tx_src, tx_dst};
		end else if (sum_en) begin
			// ten rotations bring the header back to its start
			hdr <= {hdr[143:0], hdr[159:144]};
		end else if (shift_en) begin
			hdr <= {hdr[151:0], 8'h00};
			// first shift: checksum bytes 10 and 11 land one byte up
			if (sum_d) begin
				hdr[87:72] <= ~sum;
			end
		end
		if (rd_valid) begin
			pay_q <= rd_data;
		end
	end

	assign eth_tx_valid = shift_en || pay_q_valid;
	assign eth_tx_data = shift_en ? hdr[159:152] : pay_q;

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_ipv4_over_eth -f vlog.f
./obj_dir/Vtb_ipv4_over_eth

// ==== tb_ipv4_over_eth.sv ====
`timescale 1ns/1ps

module tb_ipv4_over_eth;

	logic clk;
	logic reset;
	logic rx_frame_start;
	logic [15:0] rx_ethertype;
	logic rx_valid;
	logic [7:0] rx_data;
	logic head_valid;
	logic head_error;
	logic [5:0] head_dscp;
	logic [15:0] head_total_length;
	logic [15:0] head_id;
	logic [7:0] head_ttl;
	logic [7:0] head_protocol;
	logic [31:0] head_src;
	logic [31:0] head_dst;
	logic pay_valid;
	logic [7:0] pay_data;
	logic rx_done;
	logic rx_busy;
	logic tx_start;
	logic [5:0] tx_dscp;
	logic [15:0] tx_total_length;
	logic [15:0] tx_id;
	logic [7:0] tx_ttl;
	logic [7:0] tx_protocol;
	logic [31:0] tx_src;
	logic [31:0] tx_dst;
	logic tx_wr;
	logic [7:0] tx_wdata;
	logic eth_tx_valid;
	logic [7:0] eth_tx_data;
	logic tx_busy;
	logic tx_full;

	// header bytes as they go on the wire, options included
	logic [7:0] hdr_buf [0:59];
	logic [7:0] exp_pay [$];
	logic [7:0] exp_tx [$];
	// error, dscp, total_length, id, ttl, protocol, src, dst
	logic [118:0] exp_head;
	logic head_pending;
	logic first_pending;
	int done_count;
	int cycle;
	int start_cycle;
	int seed_val;
	string test_name;

	ipv4_over_eth dut0 (.*);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_stop();
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_head(input string name, input logic [118:0] exp,
		input logic [118:0] act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %h, actual %h", test_name, name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("** Error [%s] %s: expected %b, actual %b", test_name, name, exp, act);
			fail_stop();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("** Error [%s] %s: expected %0d, actual %0d", test_name, name, exp, act);
			fail_stop();
		end
	endtask

	// ones' complement sum of the first n header bytes taken as 16-bit words
	function automatic logic [15:0] hdr_ones_sum(input int n);
		logic [16:0] acc;
		int i;
		acc = 17'd0;
		for (i = 0; i < n; i += 2) begin
			acc = {1'b0, acc[15:0]} + {1'b0, hdr_buf[i], hdr_buf[i + 1]};
			acc = {1'b0, acc[15:0]} + {16'd0, acc[16]};
		end
		return acc[15:0];
	endfunction

	// base header with a zero checksum field
	task automatic build_header(input logic [3:0] ihl, input logic [5:0] dscp,
		input logic [15:0] tl, input logic [15:0] id, input logic [7:0] ttl,
		input logic [7:0] proto, input logic [31:0] src, input logic [31:0] dst);
		int i;
		hdr_buf[0] = {4'h4, ihl};
		hdr_buf[1] = {dscp, 2'b00};
		hdr_buf[2] = tl[15:8];
		hdr_buf[3] = tl[7:0];
		hdr_buf[4] = id[15:8];
		hdr_buf[5] = id[7:0];
		hdr_buf[6] = 8'h00;
		hdr_buf[7] = 8'h00;
		hdr_buf[8] = ttl;
		hdr_buf[9] = proto;
		hdr_buf[10] = 8'h00;
		hdr_buf[11] = 8'h00;
		for (i = 0; i < 4; i++) begin
			hdr_buf[12 + i] = src[31 - 8 * i -: 8];
			hdr_buf[16 + i] = dst[31 - 8 * i -: 8];
		end
	endtask

	task automatic drive_rx_byte(input logic [7:0] b);
		int gap;
		gap = $urandom_range(2, 0);
		rx_valid = 1'b0;
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		rx_valid = 1'b1;
		rx_data = b;
		@(posedge clk);
		#1;
		rx_valid = 1'b0;
	endtask

	task automatic send_rx(input logic [15:0] ethertype, input int ihl, input int pay_n,
		input int corrupt_idx, input int trail_n);
		logic [5:0] dscp;
		logic [15:0] tl;
		logic [15:0] id;
		logic [7:0] ttl;
		logic [7:0] proto;
		logic [31:0] src;
		logic [31:0] dst;
		logic [15:0] csum;
		logic [7:0] pay [0:63];
		int i;
		int n;
		int target;
		dscp = 6'($urandom);
		id = 16'($urandom);
		ttl = 8'($urandom);
		proto = 8'($urandom);
		src = $urandom;
		dst = $urandom;
		tl = 16'(4 * ihl + pay_n);
		build_header(4'(ihl), dscp, tl, id, ttl, proto, src, dst);
		for (i = 20; i < 4 * ihl; i++) begin
			hdr_buf[i] = 8'($urandom);
		end
		csum = ~hdr_ones_sum(4 * ihl);
		hdr_buf[10] = csum[15:8];
		hdr_buf[11] = csum[7:0];
		if (corrupt_idx >= 0) begin
			hdr_buf[corrupt_idx] = hdr_buf[corrupt_idx] ^ 8'h5a;
		end
		for (i = 0; i < pay_n; i++) begin
			pay[i] = 8'($urandom);
		end
		target = done_count;
		if (ethertype == 16'h0800) begin
			// a corrupted header byte must be flagged
			exp_head = {corrupt_idx >= 0, dscp, tl, id, ttl, proto, src, dst};
			head_pending = 1'b1;
			for (i = 0; i < pay_n; i++) begin
				exp_pay.push_back(pay[i]);
			end
			target = done_count + 1;
		end
		rx_frame_start = 1'b1;
		rx_ethertype = ethertype;
		@(posedge clk);
		#1;
		rx_frame_start = 1'b0;
		if (ethertype == 16'h0800) begin
			check_flag("rx_busy in header", 1'b1, rx_busy);
		end
		for (i = 0; i < 4 * ihl; i++) begin
			drive_rx_byte(hdr_buf[i]);
		end
		for (i = 0; i < pay_n; i++) begin
			drive_rx_byte(pay[i]);
		end
		// bytes past total_length
		for (i = 0; i < trail_n; i++) begin
			drive_rx_byte(8'($urandom));
		end
		n = 0;
		while (done_count < target && n < 200) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (done_count < target) begin
			$display("timeout waiting for rx_done in test %s", test_name);
			fail_stop();
		end
		repeat (6) begin
			@(posedge clk);
			#1;
		end
		check_count("rx_done pulses", target, done_count);
		check_flag("header still pending", 1'b0, head_pending);
		check_count("payload bytes missing", 0, exp_pay.size());
		if (ethertype == 16'h0800) begin
			check_flag("rx_busy after frame", 1'b0, rx_busy);
		end
	endtask

	task automatic write_fifo(input logic [7:0] b, input int gap);
		repeat (gap) begin
			@(posedge clk);
			#1;
		end
		check_flag("fifo full on write", 1'b0, tx_full);
		tx_wr = 1'b1;
		tx_wdata = b;
		@(posedge clk);
		#1;
		tx_wr = 1'b0;
	endtask

	task automatic send_tx(input int pay_n, input int pre_n);
		logic [7:0] pay [0:31];
		logic [15:0] csum;
		int i;
		int n;
		tx_dscp = 6'($urandom);
		tx_id = 16'($urandom);
		tx_ttl = 8'($urandom);
		tx_protocol = 8'($urandom);
		tx_src = $urandom;
		tx_dst = $urandom;
		tx_total_length = 16'(20 + pay_n);
		build_header(4'd5, tx_dscp, tx_total_length, tx_id, tx_ttl, tx_protocol,
			tx_src, tx_dst);
		csum = ~hdr_ones_sum(20);
		hdr_buf[10] = csum[15:8];
		hdr_buf[11] = csum[7:0];
		for (i = 0; i < 20; i++) begin
			exp_tx.push_back(hdr_buf[i]);
		end
		for (i = 0; i < pay_n; i++) begin
			pay[i] = 8'($urandom);
			exp_tx.push_back(pay[i]);
		end
		for (i = 0; i < pre_n; i++) begin
			write_fifo(pay[i], 0);
		end
		// 32 entries fill the fifo
		check_flag("fifo full after preload", pre_n == 32, tx_full);
		if (pre_n == 32) begin
			// this write must be dropped
			tx_wr = 1'b1;
			tx_wdata = 8'hee;
			@(posedge clk);
			#1;
			tx_wr = 1'b0;
		end
		tx_start = 1'b1;
		@(posedge clk);
		#1;
		tx_start = 1'b0;
		// the rest trickles in while the header goes out
		for (i = pre_n; i < pay_n; i++) begin
			write_fifo(pay[i], $urandom_range(3, 0));
		end
		n = 0;
		while ((exp_tx.size() != 0 || tx_busy) && n < 400) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (exp_tx.size() != 0 || tx_busy) begin
			$display("timeout waiting for the transmit frame in test %s", test_name);
			fail_stop();
		end
	endtask

	always @(posedge clk) begin : monitor
		logic [7:0] want;
		if (!reset) begin
			cycle = cycle + 1;
			if (head_valid) begin
				if (!head_pending) begin
					$display("head_valid with no header expected in test %s", test_name);
					fail_stop();
				end else begin
					check_head("head fields", exp_head, {head_error, head_dscp,
						head_total_length, head_id, head_ttl, head_protocol, head_src, head_dst});
					head_pending = 1'b0;
				end
			end
			if (pay_valid) begin
				if (exp_pay.size() == 0) begin
					$display("payload byte with none expected in test %s", test_name);
					fail_stop();
				end else begin
					want = exp_pay.pop_front();
					check_byte("rx payload byte", want, pay_data);
				end
			end
			if (rx_done) begin
				done_count = done_count + 1;
			end
			if (tx_start && !tx_busy) begin
				start_cycle = cycle;
				first_pending = 1'b1;
			end
			if (eth_tx_valid) begin
				if (exp_tx.size() == 0) begin
					$display("transmit byte with none expected in test %s", test_name);
					fail_stop();
				end else begin
					if (first_pending) begin
						check_count("first byte latency", 11, cycle - start_cycle);
						first_pending = 1'b0;
					end
					want = exp_tx.pop_front();
					check_byte("tx byte", want, eth_tx_data);
				end
			end
		end
	end

	initial begin
		seed_val = $urandom(32'h4b062d29);
		reset = 1'b1;
		rx_frame_start = 1'b0;
		rx_ethertype = 16'h0000;
		rx_valid = 1'b0;
		rx_data = 8'h00;
		tx_start = 1'b0;
		tx_dscp = 6'd0;
		tx_total_length = 16'd0;
		tx_id = 16'd0;
		tx_ttl = 8'd0;
		tx_protocol = 8'd0;
		tx_src = 32'd0;
		tx_dst = 32'd0;
		tx_wr = 1'b0;
		tx_wdata = 8'h00;
		head_pending = 1'b0;
		first_pending = 1'b0;
		done_count = 0;
		cycle = 0;
		start_cycle = 0;
		test_name = "reset";
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		check_flag("head_valid", 1'b0, head_valid);
		check_flag("pay_valid", 1'b0, pay_valid);
		check_flag("rx_done", 1'b0, rx_done);
		check_flag("rx_busy", 1'b0, rx_busy);
		check_flag("eth_tx_valid", 1'b0, eth_tx_valid);
		check_flag("tx_busy", 1'b0, tx_busy);

		test_name = "rx_basic";
		send_rx(16'h0800, 5, 16, -1, 0);
		test_name = "rx_bad_checksum";
		send_rx(16'h0800, 5, 6, 10, 0);
		test_name = "rx_other_ethertype";
		send_rx(16'h86dd, 5, 8, -1, 0);
		test_name = "rx_options";
		send_rx(16'h0800, 7, 10, -1, 5);
		test_name = "tx_basic";
		send_tx(32, 32);
		test_name = "tx_late_payload";
		send_tx(20, 4);

		$display("Testbench passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
ipv4_pkg.sv
byte_counter.sv
byte_fifo.sv
ipv4_rx_ctrl.sv
ipv4_rx_head.sv
ipv4_tx_ctrl.sv
ipv4_tx_head.sv
ipv4_over_eth.sv
tb_ipv4_over_eth.sv
